// ==== aes_accel.f ====
hw/aes_pkg.sv
hw/aes_regfile.sv
hw/aes_fsm.sv
hw/aes_streamer.sv
hw/aes_engine.sv
hw/aes_top.sv
dv/tb_aes_top.sv

// ==== dv/tb_aes_top.sv ====
`timescale 1ns/100ps

module tb_aes_top;
  import aes_pkg::*;

  localparam int ADDR_W      = 32;
  localparam int ACK_TIMEOUT = 20;
  localparam int IRQ_TIMEOUT = 1000;
  localparam int RUN_TIMEOUT = 20000;

  logic              clk;
  logic              reset_n;
  logic              s_cyc_i;
  logic              s_stb_i;
  logic              s_we_i;
  logic [3:0]        s_adr_i;
  logic [31:0]       s_dat_i;
  logic [31:0]       s_dat_o;
  logic              s_ack_o;
  logic              m_cyc_o;
  logic              m_stb_o;
  logic              m_we_o;
  logic [ADDR_W-1:0] m_adr_o;
  logic [31:0]       m_dat_o;
  logic [31:0]       m_dat_i;
  logic              m_ack_i;
  logic              irq_o;

  // Word memory behind the master port
  logic [31:0]  mem [0:255];
  int           write_count;
  int           mem_wait;
  logic         mem_pending;
  int           errors;
  int           checks;
  logic         test_done;
  logic         timed_out;

  // Request from the main flow to the checker
  logic         compare_req;
  string        cmp_name;
  logic [7:0]   cmp_dst;
  logic [127:0] cmp_exp;
  logic [31:0]  cmp_sentinel;

  aes_top #(
    .ADDR_W (ADDR_W)
  ) UUT (
    .clk     (clk),
    .reset_n (reset_n),
    .s_cyc_i (s_cyc_i),
    .s_stb_i (s_stb_i),
    .s_we_i  (s_we_i),
    .s_adr_i (s_adr_i),
    .s_dat_i (s_dat_i),
    .s_dat_o (s_dat_o),
    .s_ack_o (s_ack_o),
    .m_cyc_o (m_cyc_o),
    .m_stb_o (m_stb_o),
    .m_we_o  (m_we_o),
    .m_adr_o (m_adr_o),
    .m_dat_o (m_dat_o),
    .m_dat_i (m_dat_i),
    .m_ack_i (m_ack_i),
    .irq_o   (irq_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Expected block: XOR with key, then row r rotated left by r columns
  function automatic logic [127:0] ref_block(input logic [127:0] plain,
                                             input logic [127:0] key);
    logic [127:0] mixed;
    logic [127:0] result;
    mixed = plain ^ key;
    for (int col = 0; col < 4; col++) begin
      for (int row = 0; row < 4; row++) begin
        result[32*col + 8*row +: 8] = mixed[32*((col + row) % 4) + 8*row +: 8];
      end
    end
    return result;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERR %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic timeout_abort(input string what);
    $display("Timeout while waiting for %s", what);
    errors++;
    timed_out = 1'b1;
  endtask

  task automatic bus_write(input logic [3:0] adr, input logic [31:0] data);
    int cycles;
    @(negedge clk);
    s_cyc_i = 1'b1;
    s_stb_i = 1'b1;
    s_we_i  = 1'b1;
    s_adr_i = adr;
    s_dat_i = data;
    cycles  = 0;
    @(negedge clk);
    while (!s_ack_o && cycles < ACK_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!s_ack_o) begin
      timeout_abort("slave ack on a write");
    end
    s_cyc_i = 1'b0;
    s_stb_i = 1'b0;
    s_we_i  = 1'b0;
  endtask

  task automatic bus_read(input logic [3:0] adr, output logic [31:0] data);
    int cycles;
    @(negedge clk);
    s_cyc_i = 1'b1;
    s_stb_i = 1'b1;
    s_we_i  = 1'b0;
    s_adr_i = adr;
    cycles  = 0;
    @(negedge clk);
    while (!s_ack_o && cycles < ACK_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!s_ack_o) begin
      timeout_abort("slave ack on a read");
    end
    data    = s_dat_o;
    s_cyc_i = 1'b0;
    s_stb_i = 1'b0;
  endtask

  task automatic wait_irq(input string name);
    int cycles;
    cycles = 0;
    while (!irq_o && cycles < IRQ_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!irq_o) begin
      timeout_abort({"irq in ", name});
    end
  endtask

  // Program one block, start it and hand the result to the checker
  task automatic run_block(input string name, input logic [7:0] src, input logic [7:0] dst,
                           input logic [127:0] key, input logic [127:0] plain,
                           input bit start_twice);
    logic [31:0] status;
    int          cycles;
    for (int i = 0; i < 4; i++) begin
      mem[src + 8'(i)] = plain[32*i +: 32];
    end
    bus_write(REG_SRC, 32'(src));
    bus_write(REG_DST, 32'(dst));
    for (int i = 0; i < 4; i++) begin
      bus_write(REG_KEY0 + 4'(i), key[32*i +: 32]);
    end
    cmp_sentinel = mem[dst + 8'd4];
    write_count  = 0;
    bus_write(REG_CTRL, 32'h1);
    check_value({name, " irq cleared"}, 32'd0, {31'd0, irq_o});
    if (start_twice) begin
      bus_read(REG_STATUS, status);
      check_value({name, " busy status"}, 32'h2, status);
      // Second start lands in the middle of the store phase
      cycles = 0;
      while (!(m_cyc_o && m_we_o) && cycles < IRQ_TIMEOUT) begin
        @(negedge clk);
        cycles++;
      end
      if (!(m_cyc_o && m_we_o)) begin
        timeout_abort("the first master write");
      end
      bus_write(REG_CTRL, 32'h1);
    end
    wait_irq(name);
    repeat (20) @(negedge clk);
    bus_read(REG_STATUS, status);
    check_value({name, " done status"}, 32'h1, status);
    cmp_name    = name;
    cmp_dst     = dst;
    cmp_exp     = ref_block(plain, key);
    compare_req = 1'b1;
    cycles      = 0;
    while (compare_req && cycles < 10) begin
      @(negedge clk);
      cycles++;
    end
    if (compare_req) begin
      timeout_abort("the checker");
    end
  endtask

  // Memory model with 0 to 3 wait states per transfer
  initial begin
    m_ack_i     = 1'b0;
    m_dat_i     = 32'd0;
    mem_pending = 1'b0;
    mem_wait    = 0;
    forever begin
      @(negedge clk);
      if (m_stb_o !== m_cyc_o) begin
        errors++;
        $display("Master stb and cyc differ");
      end
      if (m_ack_i) begin
        if (m_cyc_o) begin
          errors++;
          $display("Master cycle still open in the cycle after the ack");
        end
        m_ack_i = 1'b0;
      end else if (m_cyc_o && m_stb_o) begin
        if (!mem_pending) begin
          mem_pending = 1'b1;
          mem_wait    = int'($urandom % 4);
        end
        if (mem_wait > 0) begin
          mem_wait--;
        end else begin
          mem_pending = 1'b0;
          m_ack_i     = 1'b1;
          if (m_adr_o > 32'd255) begin
            errors++;
            $display("Master address %h is outside the memory model", m_adr_o);
          end
          if (m_we_o) begin
            mem[m_adr_o[7:0]] = m_dat_o;
            write_count++;
          end else begin
            m_dat_i = mem[m_adr_o[7:0]];
          end
        end
      end
    end
  end

  // Checker compares the destination block with the reference
  initial begin
    forever begin
      @(posedge clk);
      if (compare_req) begin
        for (int i = 0; i < 4; i++) begin
          check_value(cmp_name, cmp_exp[32*i +: 32], mem[cmp_dst + 8'(i)]);
        end
        check_value({cmp_name, " sentinel"}, cmp_sentinel, mem[cmp_dst + 8'd4]);
        check_value({cmp_name, " write count"}, 32'd4, 32'(write_count));
        compare_req = 1'b0;
      end
    end
  end

  // End of run, after the test sequence or a timeout
  initial begin
    int cycles;
    test_done = 1'b0;
    timed_out = 1'b0;
    cycles    = 0;
    while (!test_done && !timed_out && cycles < RUN_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!test_done && !timed_out) begin
      errors++;
      $display("Timeout while waiting for the test sequence to end");
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    logic [31:0]  rd;
    logic [127:0] key;
    logic [127:0] plain;
    logic [7:0]   src;
    logic [7:0]   dst;
    void'($urandom(32'h2d6c));
    errors      = 0;
    checks      = 0;
    write_count = 0;
    compare_req = 1'b0;
    reset_n     = 1'b0;
    s_cyc_i     = 1'b0;
    s_stb_i     = 1'b0;
    s_we_i      = 1'b0;
    s_adr_i     = 4'd0;
    s_dat_i     = 32'd0;
    for (int i = 0; i < 256; i++) begin
      mem[8'(i)] = {16'hc0de, 8'(i), 8'(255 - i)};
    end
    repeat (5) @(negedge clk);
    reset_n = 1'b1;

    // Reset state
    check_value("reset irq", 32'd0, {31'd0, irq_o});
    check_value("reset master cyc", 32'd0, {31'd0, m_cyc_o});
    bus_read(REG_STATUS, rd);
    check_value("reset status", 32'd0, rd);

    // Register readback
    bus_write(REG_SRC, 32'h0000_0011);
    bus_write(REG_DST, 32'h0000_0090);
    for (int i = 0; i < 4; i++) begin
      bus_write(REG_KEY0 + 4'(i), 32'h1234_5600 + 32'(i));
    end
    bus_read(REG_SRC, rd);
    check_value("readback src", 32'h0000_0011, rd);
    bus_read(REG_DST, rd);
    check_value("readback dst", 32'h0000_0090, rd);
    for (int i = 0; i < 4; i++) begin
      bus_read(REG_KEY0 + 4'(i), rd);
      check_value("readback key", 32'h1234_5600 + 32'(i), rd);
    end
    bus_read(REG_CTRL, rd);
    check_value("readback ctrl", 32'd0, rd);

    // Known block
    key   = {32'h09cf4f3c, 32'habf71588, 32'h28aed2a6, 32'h2b7e1516};
    plain = {32'he0370734, 32'h313198a2, 32'h885a308d, 32'h3243f6a8};
    run_block("basic block", 8'h10, 8'h90, key, plain, 1'b0);

    // Random data under random wait states
    for (int run = 0; run < 8; run++) begin
      key   = {$urandom, $urandom, $urandom, $urandom};
      plain = {$urandom, $urandom, $urandom, $urandom};
      src   = 8'($urandom % 124);
      dst   = 8'(128 + $urandom % 123);
      run_block($sformatf("random run %0d", run), src, dst, key, plain, 1'b0);
    end

    // Start while busy must not launch a second block
    mem[8'hc4] = 32'h5e17_1e10;
    key   = {$urandom, $urandom, $urandom, $urandom};
    plain = {$urandom, $urandom, $urandom, $urandom};
    run_block("start while busy", 8'h40, 8'hc0, key, plain, 1'b1);

    test_done = 1'b1;
  end

endmodule

// ==== hw/aes_engine.sv ====
`timescale 1ns/100ps

module aes_engine
  import aes_pkg::*;
(
  input  logic         clk,
  input  logic         reset_n,
  input  logic         load_en_i,
  input  logic [1:0]   word_idx_i,
  input  logic [31:0]  rdata_i,
  input  logic         compute_en_i,
  input  logic [127:0] key_i,
  output logic [31:0]  out_word_o
);

  aes_state_t state_q;
  aes_state_t keyed;
  aes_state_t shifted;

  // AddRoundKey
  assign keyed = state_q ^ key_i;

  // ShiftRows: row r rotates left by r columns
  always_comb begin
    shifted = keyed;
    for (int c = 0; c < NUM_WORDS; c++) begin
      for (int r = 0; r < 4; r++) begin
        shifted.bytes[4*c + r] = keyed.bytes[4*((c + r) % NUM_WORDS) + r];
      end
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= '0;
    end else if (load_en_i) begin
      state_q.words[word_idx_i] <= rdata_i;
    end else if (compute_en_i) begin
      state_q <= shifted;
    end
  end

  assign out_word_o = state_q.words[word_idx_i];

endmodule

// ==== hw/aes_fsm.sv ====
`timescale 1ns/100ps

module aes_fsm
  import aes_pkg::*;
#(
  parameter int ADDR_W = 32
) (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              start_i,
  input  logic [ADDR_W-1:0] src_addr_i,
  input  logic [ADDR_W-1:0] dst_addr_i,
  input  logic              op_done_i,
  output bus_op_t           op_o,
  output logic [ADDR_W-1:0] addr_o,
  output logic              load_en_o,
  output logic [1:0]        word_idx_o,
  output logic              compute_en_o,
  output logic              busy_o,
  output logic              done_set_o
);

  fsm_state_t state_q;
  fsm_state_t state_d;
  logic [1:0] cnt_q;
  logic       last_word;

  assign last_word = (cnt_q == 2'(NUM_WORDS - 1));

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Word counter, shared by the fetch and store phases
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      cnt_q <= 2'd0;
    end else if (state_q == START || state_q == COMPUTE) begin
      cnt_q <= 2'd0;
    end else if ((state_q == FETCH || state_q == STORE) && op_done_i) begin
      cnt_q <= cnt_q + 2'd1;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = START;
        end
      end
      START:   state_d = FETCH;
      FETCH: begin
        if (op_done_i && last_word) begin
          state_d = COMPUTE;
        end
      end
      COMPUTE: state_d = STORE;
      STORE: begin
        if (op_done_i && last_word) begin
          state_d = FINISHED;
        end
      end
      FINISHED: state_d = IDLE;
      default:  state_d = IDLE;
    endcase
  end

  // Outputs follow the current state
  always_comb begin
    op_o         = OP_NONE;
    addr_o       = '0;
    load_en_o    = 1'b0;
    compute_en_o = 1'b0;
    done_set_o   = 1'b0;
    busy_o       = (state_q != IDLE);
    case (state_q)
      FETCH: begin
        op_o      = OP_READ;
        addr_o    = src_addr_i + ADDR_W'(cnt_q);
        load_en_o = op_done_i;
      end
      COMPUTE:  compute_en_o = 1'b1;
      STORE: begin
        op_o   = OP_WRITE;
        addr_o = dst_addr_i + ADDR_W'(cnt_q);
      end
      FINISHED: done_set_o = 1'b1;
      default: ;
    endcase
  end

  assign word_idx_o = cnt_q;

endmodule

// ==== hw/aes_pkg.sv ====
package aes_pkg;

  // A block is always four consecutive 32-bit words
  localparam int NUM_WORDS = 4;

  // Slave register map, in 32-bit word offsets
  localparam logic [3:0] REG_CTRL   = 4'd0;
  localparam logic [3:0] REG_STATUS = 4'd1;
  localparam logic [3:0] REG_SRC    = 4'd2;
  localparam logic [3:0] REG_DST    = 4'd3;
  localparam logic [3:0] REG_KEY0   = 4'd4;
  localparam logic [3:0] REG_KEY1   = 4'd5;
  localparam logic [3:0] REG_KEY2   = 4'd6;
  localparam logic [3:0] REG_KEY3   = 4'd7;

  // Cipher state, loaded as words and permuted as bytes
  // Byte n lives in column n/4, row n%4 (AES column-major order)
  typedef union packed {
    logic [NUM_WORDS-1:0][31:0]  words;
    logic [4*NUM_WORDS-1:0][7:0] bytes;
  } aes_state_t;

  typedef enum logic [2:0] {
    IDLE,
    START,
    FETCH,
    COMPUTE,
    STORE,
    FINISHED
  } fsm_state_t;

  // Command from the FSM to the bus master
  typedef enum logic [1:0] {
    OP_NONE,
    OP_READ,
    OP_WRITE
  } bus_op_t;

endpackage

// ==== hw/aes_regfile.sv ====
`timescale 1ns/100ps

module aes_regfile
  import aes_pkg::*;
#(
  parameter int ADDR_W = 32
) (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              s_cyc_i,
  input  logic              s_stb_i,
  input  logic              s_we_i,
  input  logic [3:0]        s_adr_i,
  input  logic [31:0]       s_dat_i,
  output logic [31:0]       s_dat_o,
  output logic              s_ack_o,
  input  logic              busy_i,
  input  logic              done_set_i,
  output logic              start_o,
  output logic [ADDR_W-1:0] src_addr_o,
  output logic [ADDR_W-1:0] dst_addr_o,
  output logic [127:0]      key_o,
  output logic              irq_o
);

  logic              access;
  logic              start_req;
  logic              done_q;
  logic [ADDR_W-1:0] src_q;
  logic [ADDR_W-1:0] dst_q;
  logic [3:0][31:0]  key_q;
  logic [31:0]       rd_data;

  // New request only when no ack is currently out
  assign access = s_cyc_i && s_stb_i && !s_ack_o;

  // Start is dropped while a block is in flight
  assign start_req = access && s_we_i && (s_adr_i == REG_CTRL) && s_dat_i[0] &&
                     !busy_i && !start_o;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      s_ack_o <= 1'b0;
      start_o <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      s_ack_o <= access;
      start_o <= start_req;
      if (start_req) begin
        done_q <= 1'b0;
      end else if (done_set_i) begin
        done_q <= 1'b1;
      end
    end
  end

  // Configuration and read data
  always_ff @(posedge clk) begin
    if (access && s_we_i) begin
      case (s_adr_i)
        REG_SRC:  src_q    <= s_dat_i[ADDR_W-1:0];
        REG_DST:  dst_q    <= s_dat_i[ADDR_W-1:0];
        REG_KEY0: key_q[0] <= s_dat_i;
        REG_KEY1: key_q[1] <= s_dat_i;
        REG_KEY2: key_q[2] <= s_dat_i;
        REG_KEY3: key_q[3] <= s_dat_i;
        default: ;
      endcase
    end
    if (access && !s_we_i) begin
      s_dat_o <= rd_data;
    end
  end

  always_comb begin
    case (s_adr_i)
      REG_STATUS: rd_data = {30'd0, busy_i, done_q};
      REG_SRC:    rd_data = 32'(src_q);
      REG_DST:    rd_data = 32'(dst_q);
      REG_KEY0:   rd_data = key_q[0];
      REG_KEY1:   rd_data = key_q[1];
      REG_KEY2:   rd_data = key_q[2];
      REG_KEY3:   rd_data = key_q[3];
      // CTRL and unused offsets read as zero
      default:    rd_data = 32'd0;
    endcase
  end

  assign src_addr_o = src_q;
  assign dst_addr_o = dst_q;
  assign key_o      = key_q;
  assign irq_o      = done_q;

endmodule

// ==== hw/aes_streamer.sv ====
`timescale 1ns/100ps

module aes_streamer
  import aes_pkg::*;
#(
  parameter int ADDR_W = 32
) (
  input  logic              clk,
  input  logic              reset_n,
  input  bus_op_t           op_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [31:0]       wdata_i,
  output logic              m_cyc_o,
  output logic              m_stb_o,
  output logic              m_we_o,
  output logic [ADDR_W-1:0] m_adr_o,
  output logic [31:0]       m_dat_o,
  input  logic [31:0]       m_dat_i,
  input  logic              m_ack_i,
  output logic [31:0]       rdata_o,
  output logic              op_done_o
);

  logic        active_q;
  logic        done_q;
  logic        launch;
  logic        ack_now;

  // One cycle of rest after each completion
  assign launch  = (op_i != OP_NONE) && !active_q && !done_q;
  assign ack_now = active_q && m_ack_i;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      active_q <= 1'b0;
      done_q   <= 1'b0;
      m_we_o   <= 1'b0;
    end else begin
      done_q <= ack_now;
      if (launch) begin
        active_q <= 1'b1;
        m_we_o   <= (op_i == OP_WRITE);
      end else if (ack_now) begin
        active_q <= 1'b0;
        m_we_o   <= 1'b0;
      end
    end
  end

  // Address and write data held for the whole transfer
  always_ff @(posedge clk) begin
    if (launch) begin
      m_adr_o <= addr_i;
      m_dat_o <= wdata_i;
    end
  end

  assign m_cyc_o   = active_q;
  assign m_stb_o   = active_q;
  assign op_done_o = ack_now;

  // Read word goes straight to the engine, which loads it in the ack cycle
  assign rdata_o = m_dat_i;

endmodule

// ==== hw/aes_top.sv ====
`timescale 1ns/100ps

module aes_top
  import aes_pkg::*;
#(
  parameter int ADDR_W = 32
) (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              s_cyc_i,
  input  logic              s_stb_i,
  input  logic              s_we_i,
  input  logic [3:0]        s_adr_i,
  input  logic [31:0]       s_dat_i,
  output logic [31:0]       s_dat_o,
  output logic              s_ack_o,
  output logic              m_cyc_o,
  output logic              m_stb_o,
  output logic              m_we_o,
  output logic [ADDR_W-1:0] m_adr_o,
  output logic [31:0]       m_dat_o,
  input  logic [31:0]       m_dat_i,
  input  logic              m_ack_i,
  output logic              irq_o
);

  logic              start_pulse;
  logic              busy;
  logic              done_set;
  logic [ADDR_W-1:0] src_addr;
  logic [ADDR_W-1:0] dst_addr;
  logic [127:0]      key;
  bus_op_t           op;
  logic [ADDR_W-1:0] op_addr;
  logic              op_done;
  logic [31:0]       rdata;
  logic              load_en;
  logic [1:0]        word_idx;
  logic              compute_en;
  logic [31:0]       out_word;

  aes_regfile #(
    .ADDR_W (ADDR_W)
  ) u_regfile (
    .clk        (clk),
    .reset_n    (reset_n),
    .s_cyc_i    (s_cyc_i),
    .s_stb_i    (s_stb_i),
    .s_we_i     (s_we_i),
    .s_adr_i    (s_adr_i),
    .s_dat_i    (s_dat_i),
    .s_dat_o    (s_dat_o),
    .s_ack_o    (s_ack_o),
    .busy_i     (busy),
    .done_set_i (done_set),
    .start_o    (start_pulse),
    .src_addr_o (src_addr),
    .dst_addr_o (dst_addr),
    .key_o      (key),
    .irq_o      (irq_o)
  );

  aes_fsm #(
    .ADDR_W (ADDR_W)
  ) u_fsm (
    .clk          (clk),
    .reset_n      (reset_n),
    .start_i      (start_pulse),
    .src_addr_i   (src_addr),
    .dst_addr_i   (dst_addr),
    .op_done_i    (op_done),
    .op_o         (op),
    .addr_o       (op_addr),
    .load_en_o    (load_en),
    .word_idx_o   (word_idx),
    .compute_en_o (compute_en),
    .busy_o       (busy),
    .done_set_o   (done_set)
  );

  aes_streamer #(
    .ADDR_W (ADDR_W)
  ) u_streamer (
    .clk       (clk),
    .reset_n   (reset_n),
    .op_i      (op),
    .addr_i    (op_addr),
    .wdata_i   (out_word),
    .m_cyc_o   (m_cyc_o),
    .m_stb_o   (m_stb_o),
    .m_we_o    (m_we_o),
    .m_adr_o   (m_adr_o),
    .m_dat_o   (m_dat_o),
    .m_dat_i   (m_dat_i),
    .m_ack_i   (m_ack_i),
    .rdata_o   (rdata),
    .op_done_o (op_done)
  );

  aes_engine u_engine (
    .clk          (clk),
    .reset_n      (reset_n),
    .load_en_i    (load_en),
    .word_idx_i   (word_idx),
    .rdata_i      (rdata),
    .compute_en_i (compute_en),
    .key_i        (key),
    .out_word_o   (out_word)
  );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary -j 0 --top-module tb_aes_top --Mdir obj_dir -f aes_accel.f
./obj_dir/Vtb_aes_top | tee sim.log
if grep -q "Simulation completed successfully" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi
